//--- design/cache_pkg.sv
/* Data cache package. Cache geometry, address field types and the
   processor request, way command and way status records */
package cache_pkg;

   localparam int NUM_SETS   = 256;
   localparam int LINE_WORDS = 4;

   // Bit positions of the address fields
   localparam int WORD_LSB  = 1;
   localparam int INDEX_LSB = 3;
   localparam int TAG_LSB   = 11;

   typedef logic [15:0] addr_t;
   typedef logic [15:0] data_t;
   typedef logic [4:0]  tag_t;
   typedef logic [7:0]  index_t;
   typedef logic [1:0]  word_t;
   typedef logic        way_t;

   localparam word_t LAST_WORD = word_t'(LINE_WORDS - 1);

   typedef struct packed {
      logic  rd;
      logic  wr;
      addr_t addr;
      data_t data;
   } cpu_req_t;

   typedef struct packed {
      logic  data_write;   // Write one word
      logic  tag_write;    // Store tag, set valid, clear dirty
      logic  set_dirty;
      word_t word;
      data_t data;
   } way_cmd_t;

   typedef struct packed {
      logic  valid;
      logic  dirty;
      tag_t  tag;
      data_t rd_data;
   } way_stat_t;

endpackage

//--- design/mem_pkg.sv
/* Backing memory package. Word address type, bank split, latency
   and the request and response records */
package mem_pkg;

   localparam int MEM_LATENCY = 2;   // Read response delay in cycles
   localparam int MEM_WORDS   = 32768;
   localparam int MEM_BANKS   = 4;
   localparam int BANK_WORDS  = MEM_WORDS / MEM_BANKS;

   typedef logic [14:0] mem_addr_t;
   typedef logic [1:0]  bank_t;
   typedef logic [12:0] row_t;

   typedef struct packed {
      logic              rd;
      logic              wr;
      mem_addr_t         addr;
      cache_pkg::data_t  data;
   } mem_req_t;

   typedef struct packed {
      logic              valid;
      cache_pkg::data_t  data;
   } mem_rsp_t;

endpackage

//--- design/cache_way.sv
/* One way of the data cache. Tag, valid, dirty and data arrays with
   a combinational lookup and clocked writes */
`timescale 1ns/1ns
`default_nettype none
module cache_way (
   input  wire logic                  clk,
   input  wire logic                  arst_n,
   input  wire cache_pkg::index_t     index,
   input  wire cache_pkg::tag_t       tag_in,
   input  wire cache_pkg::way_cmd_t   cmd,
   output cache_pkg::way_stat_t       stat
);
   import cache_pkg::*;

   tag_t  tag_mem  [NUM_SETS];
   data_t data_mem [NUM_SETS][LINE_WORDS];

   logic [NUM_SETS-1:0] valid_q;
   logic [NUM_SETS-1:0] dirty_q;

   // Reset invalidates every line
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= '0;
      end else if (cmd.tag_write) begin
         valid_q[index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (cmd.data_write) begin
         data_mem[index][cmd.word] <= cmd.data;
      end
      if (cmd.tag_write) begin
         tag_mem[index] <= tag_in;   // New line after a fill
      end
   end

   always_ff @(posedge clk) begin
      if (cmd.set_dirty) begin
         dirty_q[index] <= 1'b1;     // Processor write
      end else if (cmd.tag_write) begin
         dirty_q[index] <= 1'b0;     // Freshly filled line is clean
      end
   end

   // Lookup of the addressed set and word
   assign stat.valid   = valid_q[index];
   assign stat.dirty   = dirty_q[index];
   assign stat.tag     = tag_mem[index];
   assign stat.rd_data = data_mem[index][cmd.word];

endmodule
`default_nettype wire

//--- design/way_select.sv
/* Way selection. Compares both tags, keeps one LRU bit per set,
   picks the target way, steers the command to it and muxes its status back */
`timescale 1ns/1ns
`default_nettype none
module way_select (
   input  wire logic                  clk,
   input  wire logic                  arst_n,
   input  wire cache_pkg::index_t     index,
   input  wire cache_pkg::tag_t       tag_in,
   input  wire cache_pkg::way_cmd_t   cmd,
   input  wire logic                  lru_update,
   input  wire cache_pkg::way_stat_t  stat0,
   input  wire cache_pkg::way_stat_t  stat1,
   output cache_pkg::way_cmd_t        cmd0,
   output cache_pkg::way_cmd_t        cmd1,
   output logic                       hit,
   output cache_pkg::way_stat_t       target
);
   import cache_pkg::*;

   logic [NUM_SETS-1:0] lru_q;   // Way number of the LRU way per set
   logic hit0;
   logic hit1;
   way_t victim;
   way_t sel;

   assign hit0 = stat0.valid && (stat0.tag == tag_in);
   assign hit1 = stat1.valid && (stat1.tag == tag_in);
   assign hit  = hit0 || hit1;

   // Fill an empty way first, otherwise evict the LRU way
   always_comb begin
      if (!stat0.valid) begin
         victim = 1'b0;
      end else if (!stat1.valid) begin
         victim = 1'b1;
      end else begin
         victim = lru_q[index];
      end
   end

   assign sel = hit0 ? 1'b0 : (hit1 ? 1'b1 : victim);

   assign cmd0   = (sel == 1'b0) ? cmd : '0;
   assign cmd1   = (sel == 1'b1) ? cmd : '0;
   assign target = sel ? stat1 : stat0;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         lru_q <= '0;
      end else if (lru_update) begin
         lru_q[index] <= ~sel;   // Other way becomes LRU
      end
   end

   // A tag may live in only one way of a set
   a_single_hit : assert property (@(posedge clk) disable iff (!arst_n) !(hit0 && hit1))
      else $error("Both ways hit for index %0d tag %0d", index, tag_in);

endmodule
`default_nettype wire

//--- design/cache_ctrl.sv
/* Cache controller FSM. Serves hits, writes back dirty victims,
   fills lines from memory and reports done, hit and error */
`timescale 1ns/1ns
`default_nettype none
module cache_ctrl (
   input  wire logic                  clk,
   input  wire logic                  arst_n,
   input  wire cache_pkg::cpu_req_t   req,
   input  wire logic                  hit,
   input  wire cache_pkg::way_stat_t  target,
   input  wire mem_pkg::mem_rsp_t     mem_rsp,
   output cache_pkg::way_cmd_t        cmd,
   output logic                       lru_update,
   output mem_pkg::mem_req_t          mem_req,
   output cache_pkg::data_t           data_out,
   output logic                       done,
   output logic                       stall,
   output logic                       cache_hit,
   output logic                       err
);
   import cache_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      CHECK,
      WB,
      FILL_ISSUE,
      FILL_WAIT,
      DONE_ST
   } state_t;

   state_t state;
   state_t state_nxt;
   word_t  cnt;        // Write-back and fill issue counter
   word_t  rsp_cnt;    // Fill responses received
   tag_t   req_tag;
   index_t req_index;
   word_t  req_word;
   logic   req_bad;

   assign req_tag   = req.addr[TAG_LSB +: $bits(tag_t)];
   assign req_index = req.addr[INDEX_LSB +: $bits(index_t)];
   assign req_word  = req.addr[WORD_LSB +: $bits(word_t)];
   assign req_bad   = req.addr[0] || (req.rd && req.wr);   // Misaligned or both strobes

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= IDLE;
         cnt     <= '0;
         rsp_cnt <= '0;
      end else begin
         state <= state_nxt;
         if (state == WB || state == FILL_ISSUE) begin
            cnt <= cnt + 1'b1;   // Wraps to zero after the last word
         end else begin
            cnt <= '0;
         end
         if (state == FILL_ISSUE || state == FILL_WAIT) begin
            if (mem_rsp.valid) begin
               rsp_cnt <= rsp_cnt + 1'b1;
            end
         end else begin
            rsp_cnt <= '0;
         end
      end
   end

   always_comb begin
      state_nxt  = state;
      cmd        = '0;
      cmd.word   = req_word;
      cmd.data   = req.data;
      lru_update = 1'b0;
      mem_req    = '0;
      done       = 1'b0;
      cache_hit  = 1'b0;
      err        = 1'b0;

      case (state)
         IDLE: begin
            if (req.rd || req.wr) begin
               state_nxt = CHECK;
            end
         end
         CHECK: begin
            if (req_bad) begin
               done      = 1'b1;
               err       = 1'b1;
               state_nxt = IDLE;
            end else if (hit) begin
               done           = 1'b1;
               cache_hit      = 1'b1;
               lru_update     = 1'b1;
               cmd.data_write = req.wr;
               cmd.set_dirty  = req.wr;
               state_nxt      = IDLE;
            end else if (target.valid && target.dirty) begin
               state_nxt = WB;
            end else begin
               state_nxt = FILL_ISSUE;
            end
         end
         WB: begin
            cmd.word     = cnt;   // Victim word read out for write-back
            mem_req.wr   = 1'b1;
            mem_req.addr = {target.tag, req_index, cnt};
            mem_req.data = target.rd_data;
            if (cnt == LAST_WORD) begin
               state_nxt = FILL_ISSUE;
            end
         end
         FILL_ISSUE: begin
            mem_req.rd   = 1'b1;
            mem_req.addr = {req_tag, req_index, cnt};
            if (cnt == LAST_WORD) begin
               state_nxt = FILL_WAIT;
            end
         end
         FILL_WAIT: begin
            if (mem_rsp.valid && rsp_cnt == LAST_WORD) begin
               state_nxt = DONE_ST;
            end
         end
         DONE_ST: begin
            done           = 1'b1;
            lru_update     = 1'b1;
            cmd.data_write = req.wr;
            cmd.set_dirty  = req.wr;
            state_nxt      = IDLE;
         end
         default: state_nxt = IDLE;
      endcase

      // Fill responses go into the target way in arrival order
      if (state == FILL_ISSUE || state == FILL_WAIT) begin
         cmd.word       = rsp_cnt;
         cmd.data       = mem_rsp.data;
         cmd.data_write = mem_rsp.valid;
         cmd.tag_write  = mem_rsp.valid && (rsp_cnt == LAST_WORD);
      end
   end

   assign stall    = (state != IDLE) && !done;
   assign data_out = target.rd_data;

   a_done_pulse : assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
      else $error("done held for more than one cycle");

   a_mem_rd_wr : assert property (@(posedge clk) disable iff (!arst_n)
      !(mem_req.rd && mem_req.wr))
      else $error("Memory read and write in the same cycle");

   // Responses only come back for reads issued by the fill
   a_rsp_in_fill : assert property (@(posedge clk) disable iff (!arst_n)
      mem_rsp.valid |-> (state == FILL_ISSUE || state == FILL_WAIT))
      else $error("Memory response in state %s", state.name());

endmodule
`default_nettype wire

//--- design/main_mem.sv
/* Banked backing memory. Four word banks interleaved on the low
   address bits, reads answered after a fixed latency */
`timescale 1ns/1ns
`default_nettype none
module main_mem (
   input  wire logic               clk,
   input  wire mem_pkg::mem_req_t  req,
   output mem_pkg::mem_rsp_t       rsp
);
   import cache_pkg::*;
   import mem_pkg::*;

   bank_t bank_sel;
   row_t  row;
   bank_t sel_q;                            // Bank of the read one cycle ago
   data_t bank_rd [MEM_BANKS];
   logic [MEM_LATENCY-1:0] vld_pipe;
   data_t dat_pipe [1:MEM_LATENCY-1];

   assign bank_sel = req.addr[1:0];
   assign row      = req.addr[14:2];

   for (genvar b = 0; b < MEM_BANKS; b++) begin : g_bank
      data_t bank_mem [BANK_WORDS];
      data_t rd_q;

      initial begin
         for (int i = 0; i < BANK_WORDS; i++) begin
            bank_mem[i] = '0;
         end
      end

      always @(posedge clk) begin
         if (bank_sel == bank_t'(b)) begin
            if (req.wr) begin
               bank_mem[row] <= req.data;
            end
            if (req.rd) begin
               rd_q <= bank_mem[row];   // First stage of the read
            end
         end
      end

      assign bank_rd[b] = rd_q;
   end

   // Later latency stages take a new read every cycle
   always_ff @(posedge clk) begin
      sel_q       <= bank_sel;
      vld_pipe    <= {vld_pipe[MEM_LATENCY-2:0], req.rd};
      dat_pipe[1] <= bank_rd[sel_q];
      for (int i = 2; i < MEM_LATENCY; i++) begin
         dat_pipe[i] <= dat_pipe[i-1];
      end
   end

   assign rsp.valid = vld_pipe[MEM_LATENCY-1];
   assign rsp.data  = dat_pipe[MEM_LATENCY-1];

endmodule
`default_nettype wire

//--- design/mem_system.sv
/* Data cache memory system. Two-way write-back cache with its
   controller and way selector in front of the banked backing memory */
`timescale 1ns/1ns
`default_nettype none
module mem_system (
   input  wire logic                 clk,
   input  wire logic                 arst_n,
   input  wire cache_pkg::cpu_req_t  req,
   output cache_pkg::data_t          data_out,
   output logic                      done,
   output logic                      stall,
   output logic                      cache_hit,
   output logic                      err
);
   import cache_pkg::*;
   import mem_pkg::*;

   way_cmd_t  cmd;
   way_cmd_t  cmd0;
   way_cmd_t  cmd1;
   way_stat_t stat0;
   way_stat_t stat1;
   way_stat_t target;       // Hit way, or victim on a miss
   logic      hit;
   logic      lru_update;
   mem_req_t  mem_req;
   mem_rsp_t  mem_rsp;

   cache_ctrl i_ctrl (
      .clk        (clk),
      .arst_n     (arst_n),
      .req        (req),
      .hit        (hit),
      .target     (target),
      .mem_rsp    (mem_rsp),
      .cmd        (cmd),
      .lru_update (lru_update),
      .mem_req    (mem_req),
      .data_out   (data_out),
      .done       (done),
      .stall      (stall),
      .cache_hit  (cache_hit),
      .err        (err)
   );

   way_select i_sel (
      .clk        (clk),
      .arst_n     (arst_n),
      .index      (req.addr[INDEX_LSB +: $bits(index_t)]),
      .tag_in     (req.addr[TAG_LSB +: $bits(tag_t)]),
      .cmd        (cmd),
      .lru_update (lru_update),
      .stat0      (stat0),
      .stat1      (stat1),
      .cmd0       (cmd0),
      .cmd1       (cmd1),
      .hit        (hit),
      .target     (target)
   );

   cache_way i_way0 (
      .clk    (clk),
      .arst_n (arst_n),
      .index  (req.addr[INDEX_LSB +: $bits(index_t)]),
      .tag_in (req.addr[TAG_LSB +: $bits(tag_t)]),
      .cmd    (cmd0),
      .stat   (stat0)
   );

   cache_way i_way1 (
      .clk    (clk),
      .arst_n (arst_n),
      .index  (req.addr[INDEX_LSB +: $bits(index_t)]),
      .tag_in (req.addr[TAG_LSB +: $bits(tag_t)]),
      .cmd    (cmd1),
      .stat   (stat1)
   );

   main_mem i_mem (
      .clk (clk),
      .req (mem_req),
      .rsp (mem_rsp)
   );

endmodule
`default_nettype wire

//--- tb/tb_mem_system.sv
/* Testbench for the data cache memory system. Random reads and writes over
   a few shared sets, checked against a word memory and resident-tag model */
`timescale 1ns/1ns
module tb_mem_system;
   import cache_pkg::*;

   localparam int NUM_ACCESSES   = 400;
   localparam int TIMEOUT_CYCLES = 10000;   // About 14 cycles per access plus margin
   localparam int HIT_CYCLES     = 2;       // Drive edge to done on a hit

   logic     clk;
   logic     arst_n;
   cpu_req_t req;
   data_t    data_out;
   logic     done;
   logic     stall;
   logic     cache_hit;
   logic     err;

   data_t  model_mem [logic [14:0]];   // Last written value per word address
   tag_t   res_tag   [NUM_SETS][2];
   logic   res_valid [NUM_SETS][2];
   logic   res_lru   [NUM_SETS];       // LRU way number
   tag_t   tag_pool  [3];
   index_t set_pool  [4];
   int     cycle_cnt;
   int     n_hits;
   int     n_errors;
   int     n_refetch;                  // Reads of written words after eviction

   mem_system i_dut (
      .clk       (clk),
      .arst_n    (arst_n),
      .req       (req),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      assert (actual === expected)
         else stop_with_failure($sformatf("Fail %s expected %h actual %h",
                                          name, expected, actual));
   endtask

   function automatic logic is_resident(input index_t idx, input tag_t tag);
      return (res_valid[idx][0] && res_tag[idx][0] == tag) ||
             (res_valid[idx][1] && res_tag[idx][1] == tag);
   endfunction

   // Hit way first, then empty way 0, empty way 1, else the LRU way
   task automatic touch_line(input index_t idx, input tag_t tag);
      int way;
      if (res_valid[idx][0] && res_tag[idx][0] == tag) begin
         way = 0;
      end else if (res_valid[idx][1] && res_tag[idx][1] == tag) begin
         way = 1;
      end else if (!res_valid[idx][0]) begin
         way = 0;
      end else if (!res_valid[idx][1]) begin
         way = 1;
      end else begin
         way = int'(res_lru[idx]);
      end
      res_valid[idx][way] = 1'b1;
      res_tag[idx][way]   = tag;
      res_lru[idx]        = (way == 0);   // Other way becomes LRU
   endtask

   task automatic do_access(input logic rd, input logic wr, input addr_t addr,
                            input data_t data);
      cpu_req_t    nxt;
      logic [14:0] waddr;
      logic        bad;
      logic        exp_hit;
      data_t       exp_data;
      int          cycles;
      nxt.rd   = rd;
      nxt.wr   = wr;
      nxt.addr = addr;
      nxt.data = data;
      waddr    = addr[15:1];
      bad      = addr[0] || (rd && wr);
      exp_hit  = !bad && is_resident(addr[10:3], addr[15:11]);
      exp_data = model_mem.exists(waddr) ? model_mem[waddr] : '0;
      cycles   = 0;
      @(posedge clk);
      req <= nxt;
      do begin
         @(negedge clk);
         cycles++;
         if (!done && cycles >= 2) begin   // Cycle 1 is the accepting IDLE cycle
            assert (stall) else stop_with_failure("stall low while a request was pending");
         end
      end while (!done);
      check_value("err", 16'(bad), 16'(err));
      check_value("cache_hit", 16'(exp_hit), 16'(cache_hit));
      if (exp_hit) begin
         check_value("hit latency", 16'(HIT_CYCLES), 16'(cycles));
         n_hits++;
      end
      if (rd && !bad) begin
         check_value("read data", exp_data, data_out);
         if (!exp_hit && model_mem.exists(waddr)) begin
            n_refetch++;
         end
      end
      if (bad) begin
         n_errors++;
      end else begin
         touch_line(addr[10:3], addr[15:11]);
         if (wr) begin
            model_mem[waddr] = data;
         end
      end
      @(posedge clk);
      req <= '0;   // Strobe drops in the cycle after done
   endtask

   a_done_pulse : assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
      else stop_with_failure("done stayed high for more than one cycle");

   a_reset_quiet : assert property (@(posedge clk) !arst_n |-> !(done || stall || err))
      else stop_with_failure("done, stall or err was high during reset");

   a_err_at_done : assert property (@(posedge clk) disable iff (!arst_n) err |-> done)
      else stop_with_failure("err was raised without done");

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         stop_with_failure("Timeout, the accesses did not finish within the cycle limit");
      end
   end

   initial begin
      logic [31:0] rnd;
      logic        rd;
      logic        wr;
      addr_t       addr;
      rnd       = $urandom(32'hc19f3911);
      arst_n    = 1'b0;
      req       = '0;
      cycle_cnt = 0;
      n_hits    = 0;
      n_errors  = 0;
      n_refetch = 0;
      for (int s = 0; s < NUM_SETS; s++) begin
         res_valid[s][0] = 1'b0;
         res_valid[s][1] = 1'b0;
         res_lru[s]      = 1'b0;
      end
      rnd = $urandom;
      for (int i = 0; i < 3; i++) begin
         tag_pool[i] = tag_t'(rnd[4:0] + 5'(7 * i));   // Three distinct tags
      end
      for (int i = 0; i < 4; i++) begin
         set_pool[i] = index_t'(rnd[12:5] + 8'(37 * i));
      end
      repeat (4) @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      assert (!done && !stall && !err) else stop_with_failure("Outputs not idle after reset");
      for (int i = 0; i < NUM_ACCESSES; i++) begin
         rnd  = $urandom;
         addr = {tag_pool[int'(rnd[1:0]) % 3], set_pool[rnd[3:2]], rnd[5:4],
                 rnd[11:7] == 5'd0};                  // Rare odd address
         rd   = rnd[6] || (rnd[16:12] == 5'd0);
         wr   = !rnd[6] || (rnd[16:12] == 5'd0);     // Rare rd with wr
         do_access(rd, wr, addr, rnd[31:16]);
      end
      if (n_hits == 0 || n_errors == 0 || n_refetch == 0) begin
         stop_with_failure("Stimulus never reached hits, errors or reads after eviction");
      end else begin
         $display("All checks passed");
         $finish;
      end
   end

endmodule

//--- filelist.f
design/cache_pkg.sv
design/mem_pkg.sv
design/cache_way.sv
design/way_select.sv
design/cache_ctrl.sv
design/main_mem.sv
design/mem_system.sv
tb/tb_mem_system.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
TOP       := tb_mem_system
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
